// ==== flist.f ====
rob_pkg.sv
rob_sdp_ram.sv
rob_ring_ptrs.sv
rob_ready_scan.sv
rob_top.sv
rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ROB testbench with Verilator, runs it and checks for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rob_tb -f flist.f -o rob_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rob_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

// ==== rob_tb.sv ====
module rob_tb
    import rob_pkg::*;
();

    localparam int N_ENTRIES  = ROB_DEFAULT_ENTRIES;
    localparam int DATA_BITS  = ROB_DEFAULT_DATA_BITS;
    localparam int META_BITS  = ROB_DEFAULT_META_BITS;
    localparam int IDX_BITS   = $clog2(N_ENTRIES);
    localparam int RAND_STEPS = 1500;
    localparam int WAIT_LIMIT = 500;

    typedef logic [IDX_BITS-1:0]  idx_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [META_BITS-1:0] meta_t;

    // One allocated slot of the reference model, kept in allocation order
    typedef struct packed {
        idx_t  idx;
        meta_t meta;
        data_t data;
        logic  written;
    } slot_t;

    logic  clk;
    logic  reset_n;
    logic  alloc;
    meta_t alloc_meta;
    logic  not_full;
    idx_t  alloc_idx;
    logic  wr_en;
    idx_t  wr_idx;
    data_t wr_data;
    logic  deq_en;
    logic  not_empty;
    data_t first_data;
    meta_t first_meta;

    slot_t model_q [$];
    idx_t  next_idx;
    logic  pipe_vld  [ROB_READ_LATENCY];
    data_t pipe_data [ROB_READ_LATENCY];
    meta_t pipe_meta [ROB_READ_LATENCY];
    int    checks;
    int    mismatches;
    int    timeouts;
    int    deq_count;
    int    guard;

    rob_top #(
        .N_ENTRIES (N_ENTRIES),
        .DATA_BITS (DATA_BITS),
        .META_BITS (META_BITS)
    ) rob_top_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .first_data (first_data),
        .first_meta (first_meta)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // Checking helpers
    // ======================================================================

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            mismatches++;
            $display("FAIL %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
    endtask

    function automatic bit pipe_busy();
        bit busy;
        busy = 1'b0;
        for (int i = 0; i < ROB_READ_LATENCY; i++)
        begin
            busy = busy | pipe_vld[i];
        end
        return busy;
    endfunction

    // Compares everything the DUT shows at a falling edge with the model
    // The model has already seen every input the DUT has sampled so far
    task automatic check_outputs();
        // The last pipeline stage holds the entry dequeued two edges ago
        if (pipe_vld[ROB_READ_LATENCY-1])
        begin
            check_value(64'(first_data), 64'(pipe_data[ROB_READ_LATENCY-1]), "first_data");
            check_value(64'(first_meta), 64'(pipe_meta[ROB_READ_LATENCY-1]), "first_meta");
        end
        // Full is reported one slot before the ring is really full
        check_value(64'(not_full), 64'(model_q.size() < N_ENTRIES - 1), "not_full");
        check_value(64'(alloc_idx), 64'(next_idx), "alloc_idx");
        // A ready head must exist in the model and must hold its payload
        if (not_empty)
        begin
            check_value(64'(model_q.size() != 0), 64'(1), "not_empty with an empty model");
            if (model_q.size() != 0)
            begin
                check_value(64'(model_q[0].written), 64'(1), "not_empty before head write");
            end
        end
    endtask

    // ======================================================================
    // One cycle of random traffic
    // ======================================================================

    // Checks the outputs, then drives the next set of inputs on the falling edge
    task automatic step(input bit allow_alloc, input bit allow_deq);
        slot_t rec;
        int    start;
        int    pos;
        bit    found;
        @(negedge clk);
        check_outputs();
        alloc  = 1'b0;
        wr_en  = 1'b0;
        deq_en = 1'b0;
        for (int i = ROB_READ_LATENCY - 1; i > 0; i--)
        begin
            pipe_vld[i]  = pipe_vld[i-1];
            pipe_data[i] = pipe_data[i-1];
            pipe_meta[i] = pipe_meta[i-1];
        end
        pipe_vld[0] = 1'b0;
        // Dequeue the model head and expect it at the output later
        if (allow_deq && not_empty && (model_q.size() != 0) && (($urandom % 3) != 0))
        begin
            rec          = model_q.pop_front();
            pipe_vld[0]  = 1'b1;
            pipe_data[0] = rec.data;
            pipe_meta[0] = rec.meta;
            deq_en       = 1'b1;
            deq_count++;
        end
        // Payload goes to a random slot that is still waiting, so writes
        // arrive out of order
        if ((model_q.size() != 0) && (($urandom % 4) != 0))
        begin
            start = int'($urandom % model_q.size());
            found = 1'b0;
            for (int k = 0; k < model_q.size(); k++)
            begin
                pos = (start + k) % model_q.size();
                if (!found && !model_q[pos].written)
                begin
                    found       = 1'b1;
                    rec         = model_q[pos];
                    rec.data    = data_t'({$urandom, $urandom});
                    rec.written = 1'b1;
                    model_q[pos] = rec;
                    wr_en       = 1'b1;
                    wr_idx      = rec.idx;
                    wr_data     = rec.data;
                end
            end
        end
        // Allocation is pushed last so a new slot is never written in its own cycle
        if (allow_alloc && not_full && (($urandom % 4) != 0))
        begin
            rec.idx     = next_idx;
            rec.meta    = meta_t'($urandom);
            rec.data    = '0;
            rec.written = 1'b0;
            model_q.push_back(rec);
            alloc      = 1'b1;
            alloc_meta = rec.meta;
            next_idx   = next_idx + idx_t'(1);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        void'($urandom(32'h8693f537));
        clk        = 1'b0;
        reset_n    = 1'b0;
        alloc      = 1'b0;
        alloc_meta = '0;
        wr_en      = 1'b0;
        wr_idx     = '0;
        wr_data    = '0;
        deq_en     = 1'b0;
        next_idx   = '0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        deq_count  = 0;
        for (int i = 0; i < ROB_READ_LATENCY; i++)
        begin
            pipe_vld[i]  = 1'b0;
            pipe_data[i] = '0;
            pipe_meta[i] = '0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Idle state straight out of reset
        @(negedge clk);
        check_value(64'(not_empty), 64'(0), "not_empty after reset");
        check_value(64'(not_full), 64'(1), "not_full after reset");
        check_value(64'(alloc_idx), 64'(0), "alloc_idx after reset");

        // Mixed traffic that wraps the ring many times
        for (int n = 0; n < RAND_STEPS; n++)
        begin
            step(1'b1, 1'b1);
        end

        // No dequeues until the allocator is throttled
        guard = 0;
        while (not_full && (guard < WAIT_LIMIT))
        begin
            step(1'b1, 1'b0);
            guard++;
        end
        if (guard >= WAIT_LIMIT)
        begin
            report_timeout("not_full to drop");
        end
        check_value(64'(model_q.size()), 64'(N_ENTRIES - 1), "occupancy when full");

        // Drain everything, including the read pipeline
        guard = 0;
        while (((model_q.size() != 0) || pipe_busy()) && (guard < WAIT_LIMIT))
        begin
            step(1'b0, 1'b1);
            guard++;
        end
        if (guard >= WAIT_LIMIT)
        begin
            report_timeout("the ROB to drain");
        end

        // Enough dequeues to flip the trip tag several times
        check_value(64'(deq_count > 4 * N_ENTRIES), 64'(1), "more than four trips");

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0))
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== rob_top.sv ====
module rob_top
    import rob_pkg::*;
#(
    parameter int N_ENTRIES = ROB_DEFAULT_ENTRIES,
    parameter int DATA_BITS = ROB_DEFAULT_DATA_BITS,
    parameter int META_BITS = ROB_DEFAULT_META_BITS
)
(
    input  logic                         clk,
    input  logic                         reset_n,

    // Allocation of a slot together with its meta-data
    input  logic                         alloc,
    input  logic [META_BITS-1:0]         alloc_meta,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,

    // Payload write by slot index, always accepted
    input  logic                         wr_en,
    input  logic [$clog2(N_ENTRIES)-1:0] wr_idx,
    input  logic [DATA_BITS-1:0]         wr_data,

    // Ordered output, valid ROB_READ_LATENCY cycles after deq_en
    input  logic                         deq_en,
    output logic                         not_empty,
    output logic [DATA_BITS-1:0]         first_data,
    output logic [META_BITS-1:0]         first_meta
);

    logic [$clog2(N_ENTRIES)-1:0] oldest;
    logic                         trip_tag;

    // ======================================================================
    // Control
    // ======================================================================

    // Allocation order, full indication and the trip parity of the ring
    rob_ring_ptrs #(
        .N_ENTRIES (N_ENTRIES)
    ) ring_ptrs_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc     (alloc),
        .deq_en    (deq_en),
        .alloc_idx (alloc_idx),
        .not_full  (not_full),
        .oldest    (oldest),
        .trip_tag  (trip_tag)
    );

    // Tracks payload arrival and reports when the oldest entry is ready
    rob_ready_scan #(
        .N_ENTRIES (N_ENTRIES)
    ) ready_scan_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .oldest    (oldest),
        .trip_tag  (trip_tag),
        .deq_en    (deq_en),
        .not_empty (not_empty)
    );

    // ======================================================================
    // Storage
    // ======================================================================

    // Payload arrives in any order and is written by slot index
    rob_sdp_ram #(
        .DEPTH (N_ENTRIES),
        .WIDTH (DATA_BITS)
    ) data_ram (
        .clk   (clk),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_data),
        .raddr (oldest),
        .rdata (first_data)
    );

    // Meta-data is stored at the slot handed out by the allocation
    rob_sdp_ram #(
        .DEPTH (N_ENTRIES),
        .WIDTH (META_BITS)
    ) meta_ram (
        .clk   (clk),
        .wen   (alloc),
        .waddr (alloc_idx),
        .wdata (alloc_meta),
        .raddr (oldest),
        .rdata (first_meta)
    );

endmodule

// ==== rob_ready_scan.sv ====
module rob_ready_scan
    import rob_pkg::*;
#(
    parameter int N_ENTRIES = ROB_DEFAULT_ENTRIES
)
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         wr_en,
    input  logic [$clog2(N_ENTRIES)-1:0] wr_idx,
    input  logic [$clog2(N_ENTRIES)-1:0] oldest,
    input  logic                         trip_tag,
    input  logic                         deq_en,
    output logic                         not_empty
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    typedef logic [IDX_BITS-1:0]           idx_t;
    typedef logic [ROB_READY_CNT_BITS-1:0] cnt_t;

    logic [N_ENTRIES-1:0] valid_bits;
    idx_t                 scan_ptr;
    logic                 scan_tgt;
    logic                 scan_hit;
    logic                 scan_step;
    cnt_t                 ready_cnt;
    cnt_t                 ready_cnt_next;
    logic                 not_empty_q;

    // ======================================================================
    // Valid bits
    // ======================================================================

    // Each slot has one valid bit and its meaning alternates on every trip
    // around the ring
    // On the first trip a set bit reads 1, on the second trip it reads 0,
    // and so on
    // This way a bit left over from the previous trip already reads as
    // not valid and nothing has to clear it at dequeue
    //
    // A slot at or after the oldest index belongs to the current trip
    // A slot below the oldest index has already wrapped and belongs to the
    // next trip, so it is marked with the inverted tag
    // The index, the oldest pointer and the tag are all sampled in the
    // write cycle, which keeps them consistent with one another
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_bits <= '0;
        end
        else if (wr_en)
        begin
            valid_bits[wr_idx] <= (wr_idx >= oldest) ? trip_tag : ~trip_tag;
        end
    end

    // ======================================================================
    // In-order readiness scan
    // ======================================================================

    // The scan pointer walks the ring in allocation order and stops at the
    // first slot whose payload has not arrived yet
    // Its target tag follows the same trip parity as the valid bits
    assign scan_hit  = (valid_bits[scan_ptr] == scan_tgt);

    // Stop once the counter is saturated so it can never wrap
    // The scan then resumes as soon as a dequeue frees a count
    assign scan_step = scan_hit && (ready_cnt != '1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            scan_ptr <= '0;
            scan_tgt <= 1'b1;
        end
        else if (scan_step)
        begin
            scan_ptr <= scan_ptr + idx_t'(1);
            // Crossing the last slot starts a new trip for the scan as well
            if (&scan_ptr)
            begin
                scan_tgt <= ~scan_tgt;
            end
        end
    end

    // ======================================================================
    // Ready-entry counter
    // ======================================================================

    // The counter holds the number of scanned entries that are ready and
    // not yet dequeued
    // Each scan step adds one and each dequeue takes one away
    assign ready_cnt_next = ready_cnt + cnt_t'(scan_step) - cnt_t'(deq_en);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ready_cnt   <= '0;
            not_empty_q <= 1'b0;
        end
        else
        begin
            ready_cnt   <= ready_cnt_next;
            // Registered from the next count so that not_empty always
            // agrees with the count held in the same cycle
            not_empty_q <= (ready_cnt_next != '0);
        end
    end

    assign not_empty = not_empty_q;

    // The consumer may only dequeue an entry that has been reported ready
    assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> not_empty)
    else $error("rob_ready_scan: deq_en while empty");

endmodule

// ==== rob_ring_ptrs.sv ====
module rob_ring_ptrs
    import rob_pkg::*;
#(
    parameter int N_ENTRIES = ROB_DEFAULT_ENTRIES
)
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         alloc,
    input  logic                         deq_en,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] oldest,
    output logic                         trip_tag
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    typedef logic [IDX_BITS-1:0] idx_t;

    idx_t newest;
    idx_t oldest_ptr;
    idx_t occupancy;
    logic tag;

    // The wrapped index arithmetic only works for a power-of-two ring
    if (((N_ENTRIES & (N_ENTRIES - 1)) != 0) || (N_ENTRIES < 4))
    begin : g_bad_depth
        $error("rob_ring_ptrs needs N_ENTRIES to be a power of two of at least 4");
    end

    // ======================================================================
    // Allocation and dequeue pointers
    // ======================================================================

    // The newest pointer names the slot that the next allocation receives
    // Slots are handed out strictly in ring order, one per cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            newest <= '0;
        end
        else if (alloc)
        begin
            newest <= newest + idx_t'(1);
        end
    end

    // The oldest pointer follows the dequeues in the same ring order
    // The tag flips each time the oldest pointer steps past the last slot,
    // which marks the start of a new trip around the ring
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_ptr <= '0;
            tag        <= 1'b1;
        end
        else if (deq_en)
        begin
            oldest_ptr <= oldest_ptr + idx_t'(1);
            if (&oldest_ptr)
            begin
                tag <= ~tag;
            end
        end
    end

    // The wrapped difference of the pointers is the number of live entries
    // It never reaches N_ENTRIES because one slot is always held back
    assign occupancy = newest - oldest_ptr;

    // Full is declared one slot early so the pointers never meet while full
    assign not_full  = (occupancy < idx_t'(N_ENTRIES - 1));

    assign alloc_idx = newest;
    assign oldest    = oldest_ptr;
    assign trip_tag  = tag;

    // ======================================================================
    // Checks on the surrounding logic
    // ======================================================================

    // The producer has to respect not_full
    assert property (@(posedge clk) disable iff (!reset_n)
        alloc |-> not_full)
    else $error("rob_ring_ptrs: alloc while full");

    // A dequeue is only legal for an allocated entry, otherwise the oldest
    // pointer would overtake the newest one
    assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> (occupancy != '0))
    else $error("rob_ring_ptrs: dequeue would cross the allocation pointer");

endmodule

// ==== rob_sdp_ram.sv ====
module rob_sdp_ram
    import rob_pkg::*;
#(
    parameter int DEPTH = ROB_DEFAULT_ENTRIES,
    parameter int WIDTH = ROB_DEFAULT_DATA_BITS
)
(
    input  logic                     clk,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    localparam int ADDR_BITS  = $clog2(DEPTH);
    // The registered read address is the first stage of the read latency
    localparam int OUT_STAGES = ROB_READ_LATENCY - 1;

    logic [WIDTH-1:0]     mem [DEPTH];
    logic                 wen_q;
    logic [ADDR_BITS-1:0] waddr_q;
    logic [WIDTH-1:0]     wdata_q;
    logic [ADDR_BITS-1:0] raddr_q;
    logic [WIDTH-1:0]     rd_pipe [OUT_STAGES];

    // Writes are captured in a register stage and committed one edge later
    always_ff @(posedge clk)
    begin
        wen_q   <= wen;
        waddr_q <= waddr;
        wdata_q <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
    end

    // The array is read from the registered address and the result walks
    // through the output registers, so data follows the address by exactly
    // ROB_READ_LATENCY edges
    always_ff @(posedge clk)
    begin
        raddr_q    <= raddr;
        rd_pipe[0] <= mem[raddr_q];
        for (int i = 1; i < OUT_STAGES; i++)
        begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rdata = rd_pipe[OUT_STAGES-1];

endmodule

// ==== rob_pkg.sv ====
package rob_pkg;

    // ======================================================================
    // Default geometry of the reorder buffer
    // ======================================================================

    // Number of slots in the ring, which has to be a power of two
    parameter int ROB_DEFAULT_ENTRIES = 32;

    // Width of the late-arriving payload
    parameter int ROB_DEFAULT_DATA_BITS = 64;

    // Width of the meta-data captured when a slot is allocated
    parameter int ROB_DEFAULT_META_BITS = 8;

    // ======================================================================
    // Timing and bookkeeping constants
    // ======================================================================

    // Cycles from the edge that samples deq_en to valid output data
    parameter int ROB_READ_LATENCY = 2;

    // The ready counter only has to run a few entries ahead of the output
    // So three bits are plenty and keep the compare logic small
    parameter int ROB_READY_CNT_BITS = 3;

endpackage
